//--- rtl/simon_pkg.sv
`default_nettype none

package simon_pkg;

    // ************************************************************
    // Simon 32/64 dimensions
    // ************************************************************
    localparam int word_w     = 16;
    localparam int block_w    = 2 * word_w;
    localparam int key_w      = 4 * word_w;
    localparam int num_rounds = 32;

    // Bit j holds z0[j]
    localparam logic [61:0] z0_seq =
        62'b01100111000011010100100010111110110011100001101010010001011111;

    typedef logic [word_w-1:0] word_t;
    typedef logic [4:0]        round_idx_t;

    typedef struct packed {
        word_t left;   // x word, upper half of the block
        word_t right;  // y word
    } block_t;

    // ************************************************************
    // Register map and control encodings
    // ************************************************************
    typedef enum logic [7:0] {
        addr_key_lo     = 8'd0,
        addr_key_hi     = 8'd1,
        addr_plaintext  = 8'd2,
        addr_ciphertext = 8'd3,
        addr_enc_result = 8'd4,
        addr_dec_result = 8'd5,
        addr_enc_start  = 8'd6,
        addr_dec_start  = 8'd7,
        addr_enc_done   = 8'd8,
        addr_dec_done   = 8'd9,
        addr_status     = 8'd10
    } reg_addr_e;

    typedef enum logic {
        dir_encrypt,
        dir_decrypt
    } cipher_dir_e;

    typedef enum logic [1:0] {
        idle,
        wait_key,
        run,
        done
    } core_state_e;

    typedef struct packed {
        logic               write;
        logic [7:0]         addr;
        logic [block_w-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [block_w-1:0] rdata;
    } bus_rsp_t;

    function automatic word_t rol(word_t x, int unsigned n);
        return (x << n) | (x >> (word_w - n));
    endfunction

    function automatic word_t ror(word_t x, int unsigned n);
        return (x >> n) | (x << (word_w - n));
    endfunction

    // Simon round function
    function automatic word_t simon_f(word_t x);
        return (rol(x, 1) & rol(x, 8)) ^ rol(x, 2);
    endfunction

endpackage

`default_nettype wire

//--- rtl/simon_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module simon_key_schedule
    import simon_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [key_w-1:0] key,
    input  logic             key_load,
    output logic             key_ready,
    input  round_idx_t       enc_idx,
    output word_t            enc_rk,
    input  round_idx_t       dec_idx,
    output word_t            dec_rk
);

    word_t      rk_table [num_rounds];
    round_idx_t gen_idx;     // Next key to compute
    logic       expanding;
    word_t      mix;
    word_t      next_rk;

    // ************************************************************
    // Round key generation, m = 4
    // ************************************************************
    always_comb begin
        mix = ror(rk_table[gen_idx - round_idx_t'(1)], 3)
            ^ rk_table[gen_idx - round_idx_t'(3)];
        mix = mix ^ ror(mix, 1);
        next_rk = ~rk_table[gen_idx - round_idx_t'(4)] ^ mix
                ^ word_t'(z0_seq[gen_idx - round_idx_t'(4)])
                ^ word_t'(3);
    end

    // Table itself holds no reset
    always_ff @(posedge clk) begin
        if (key_load) begin
            for (int i = 0; i < 4; i++) begin
                rk_table[i] <= key[i*word_w +: word_w];  // k0 is the low word
            end
        end else if (expanding) begin
            rk_table[gen_idx] <= next_rk;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            expanding <= 1'b0;
            gen_idx   <= '0;
            key_ready <= 1'b0;
        end else if (key_load) begin
            expanding <= 1'b1;
            gen_idx   <= round_idx_t'(4);
            key_ready <= 1'b0;
        end else if (expanding) begin
            gen_idx <= gen_idx + round_idx_t'(1);
            if (gen_idx == round_idx_t'(num_rounds - 1)) begin
                expanding <= 1'b0;
                key_ready <= 1'b1;  // Last key written this edge
            end
        end
    end

    assign enc_rk = rk_table[enc_idx];
    assign dec_rk = rk_table[dec_idx];

    // ************************************************************
    // Checks
    // ************************************************************
    // Cores must never see a half built table
    a_ready_low_during_expansion: assert property (
        @(posedge clk) disable iff (!reset)
        key_load |=> !key_ready [*(num_rounds - 4)]
    ) else $error("key_ready high during key expansion");

endmodule

`default_nettype wire

//--- rtl/simon_round_core.sv
`timescale 1ns/1ps
`default_nettype none

module simon_round_core
    import simon_pkg::*;
#(
    parameter cipher_dir_e dir = dir_encrypt
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  block_t     data_in,
    input  logic       key_ready,
    output round_idx_t rk_idx,
    input  word_t      rk,
    output block_t     data_out,
    output logic       busy,
    output logic       done
);

    core_state_e state;
    round_idx_t  round_cnt;
    block_t      blk;
    block_t      blk_next;

    // ************************************************************
    // One Feistel round per cycle
    // ************************************************************
    always_comb begin
        if (dir == dir_encrypt) begin
            blk_next.left  = blk.right ^ simon_f(blk.left) ^ rk;
            blk_next.right = blk.left;
        end else begin
            blk_next.left  = blk.right;  // Undo the swap
            blk_next.right = blk.left ^ simon_f(blk.right) ^ rk;
        end
    end

    // Decryption walks the table backwards
    assign rk_idx = (dir == dir_encrypt) ? round_cnt
                                         : round_idx_t'(num_rounds - 1) - round_cnt;

    // ************************************************************
    // Control FSM
    // ************************************************************
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= idle;
            round_cnt <= '0;
            blk       <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        blk       <= data_in;
                        round_cnt <= '0;
                        if (key_ready) begin
                            state <= run;
                        end else begin
                            state <= wait_key;  // Table still expanding
                        end
                    end
                end
                wait_key: begin
                    if (key_ready) begin
                        state <= run;
                    end
                end
                run: begin
                    blk       <= blk_next;
                    round_cnt <= round_cnt + round_idx_t'(1);  // Wraps back to 0
                    if (round_cnt == round_idx_t'(num_rounds - 1)) begin
                        state <= simon_pkg::done;
                    end
                end
                simon_pkg::done: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    assign data_out = blk;
    assign busy     = (state != idle);
    assign done     = (state == simon_pkg::done);

    // ************************************************************
    // Checks
    // ************************************************************
    a_idx_stable_idle: assert property (
        @(posedge clk) disable iff (!reset)
        (state == idle) ##1 (state == idle) |-> $stable(rk_idx)
    ) else $error("round key index moved while idle");

endmodule

`default_nettype wire

//--- rtl/simon_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module simon_reg_block
    import simon_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  bus_req_t         bus_in,
    output logic             ack,
    output bus_rsp_t         bus_out,
    output logic [key_w-1:0] key,
    output logic             key_load,
    input  logic             key_ready,
    output block_t           enc_data,
    output logic             enc_start,
    input  block_t           enc_result,
    input  logic             enc_busy,
    input  logic             enc_done,
    output block_t           dec_data,
    output logic             dec_start,
    input  block_t           dec_result,
    input  logic             dec_busy,
    input  logic             dec_done
);

    reg_addr_e          addr;
    logic               access;      // req seen, ack not yet up
    logic               wr;
    logic               rd;
    logic [block_w-1:0] rd_data;
    logic               enc_flag;
    logic               dec_flag;
    logic               enc_clr;
    logic               dec_clr;
    logic               key_loaded;
    logic               key_busy;

    assign addr   = reg_addr_e'(bus_in.addr);
    assign access = req && !ack;
    assign wr     = access && bus_in.write;
    assign rd     = access && !bus_in.write;

    // Covers the cycle before key_ready falls
    assign key_busy = key_loaded && (key_load || !key_ready);

    // ************************************************************
    // Read mux
    // ************************************************************
    always_comb begin
        rd_data = '0;
        case (addr)
            addr_key_lo:     rd_data = key[block_w-1:0];
            addr_key_hi:     rd_data = key[key_w-1:block_w];
            addr_plaintext:  rd_data = enc_data;
            addr_ciphertext: rd_data = dec_data;
            addr_enc_result: rd_data = enc_result;
            addr_dec_result: rd_data = dec_result;
            addr_enc_done:   rd_data = {{(block_w-1){1'b0}}, enc_flag};
            addr_dec_done:   rd_data = {{(block_w-1){1'b0}}, dec_flag};
            addr_status:     rd_data = {{(block_w-3){1'b0}}, dec_busy, enc_busy, key_busy};
            default:         rd_data = '0;  // Unmapped
        endcase
    end

    // ************************************************************
    // Four-phase slave and register writes
    // ************************************************************
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ack        <= 1'b0;
            bus_out    <= '0;
            key        <= '0;
            key_load   <= 1'b0;
            key_loaded <= 1'b0;
            enc_data   <= '0;
            dec_data   <= '0;
            enc_start  <= 1'b0;
            dec_start  <= 1'b0;
        end else begin
            key_load  <= 1'b0;
            enc_start <= 1'b0;
            dec_start <= 1'b0;
            if (access) begin
                ack <= 1'b1;
                if (bus_in.write) begin
                    case (addr)
                        addr_key_lo: key[block_w-1:0] <= bus_in.wdata;
                        addr_key_hi: begin
                            key[key_w-1:block_w] <= bus_in.wdata;
                            key_load             <= 1'b1;  // Kick off expansion
                            key_loaded           <= 1'b1;
                        end
                        addr_plaintext:  enc_data  <= bus_in.wdata;
                        addr_ciphertext: dec_data  <= bus_in.wdata;
                        addr_enc_start:  enc_start <= 1'b1;
                        addr_dec_start:  dec_start <= 1'b1;
                        default: ;
                    endcase
                end else begin
                    bus_out.rdata <= rd_data;
                end
            end else if (!req && ack) begin
                ack <= 1'b0;
            end
        end
    end

    // ************************************************************
    // Sticky done flags
    // ************************************************************
    assign enc_clr = (rd && addr == addr_enc_done) || (wr && addr == addr_plaintext);
    assign dec_clr = (rd && addr == addr_dec_done) || (wr && addr == addr_ciphertext);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            enc_flag <= 1'b0;
            dec_flag <= 1'b0;
        end else begin
            enc_flag <= (enc_flag && !enc_clr) || enc_done;  // New done wins
            dec_flag <= (dec_flag && !dec_clr) || dec_done;
        end
    end

    // ************************************************************
    // Checks
    // ************************************************************
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    a_enc_start_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        enc_start |=> !enc_start
    ) else $error("enc_start longer than one cycle");

    a_dec_start_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        dec_start |=> !dec_start
    ) else $error("dec_start longer than one cycle");

endmodule

`default_nettype wire

//--- rtl/simon_crypto_top.sv
`timescale 1ns/1ps
`default_nettype none

module simon_crypto_top
    import simon_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  bus_req_t bus_in,
    output logic     ack,
    output bus_rsp_t bus_out
);

    logic [key_w-1:0] key;
    logic             key_load;
    logic             key_ready;
    block_t           enc_data;
    block_t           enc_result;
    block_t           dec_data;
    block_t           dec_result;
    logic             enc_start;
    logic             enc_busy;
    logic             enc_done;
    logic             dec_start;
    logic             dec_busy;
    logic             dec_done;
    round_idx_t       enc_idx;
    round_idx_t       dec_idx;
    word_t            enc_rk;
    word_t            dec_rk;

    simon_reg_block simon_reg_block_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .bus_in     (bus_in),
        .ack        (ack),
        .bus_out    (bus_out),
        .key        (key),
        .key_load   (key_load),
        .key_ready  (key_ready),
        .enc_data   (enc_data),
        .enc_start  (enc_start),
        .enc_result (enc_result),
        .enc_busy   (enc_busy),
        .enc_done   (enc_done),
        .dec_data   (dec_data),
        .dec_start  (dec_start),
        .dec_result (dec_result),
        .dec_busy   (dec_busy),
        .dec_done   (dec_done)
    );

    // Shared round key table
    simon_key_schedule simon_key_schedule_inst (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .key_load  (key_load),
        .key_ready (key_ready),
        .enc_idx   (enc_idx),
        .enc_rk    (enc_rk),
        .dec_idx   (dec_idx),
        .dec_rk    (dec_rk)
    );

    simon_round_core #(
        .dir (dir_encrypt)
    ) simon_encrypt_core_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (enc_start),
        .data_in   (enc_data),
        .key_ready (key_ready),
        .rk_idx    (enc_idx),
        .rk        (enc_rk),
        .data_out  (enc_result),
        .busy      (enc_busy),
        .done      (enc_done)
    );

    simon_round_core #(
        .dir (dir_decrypt)
    ) simon_decrypt_core_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (dec_start),
        .data_in   (dec_data),
        .key_ready (key_ready),
        .rk_idx    (dec_idx),
        .rk        (dec_rk),
        .data_out  (dec_result),
        .busy      (dec_busy),
        .done      (dec_done)
    );

endmodule

`default_nettype wire

//--- tb/simon_tb_model.svh
`ifndef SIMON_TB_MODEL_SVH
`define SIMON_TB_MODEL_SVH

`default_nettype none

// ************************************************************
// Simon 32/64 reference model
// ************************************************************

// z0 written first bit first, so z0[j] sits at bit 61 - j
localparam logic [61:0] model_z0 =
    62'b11111010001001010110000111001101111101000100101011000011100110;

function automatic logic [15:0] rotl16(input logic [15:0] x, input int n);
    return (x << n) | (x >> (16 - n));
endfunction

function automatic logic [15:0] rotr16(input logic [15:0] x, input int n);
    return (x >> n) | (x << (16 - n));
endfunction

function automatic logic [15:0] round_fn(input logic [15:0] x);
    return (rotl16(x, 1) & rotl16(x, 8)) ^ rotl16(x, 2);
endfunction

function automatic logic [15:0] expand_round_key(input logic [63:0] key, input int idx);
    logic [15:0] k [32];
    logic [15:0] tmp;
    for (int i = 0; i < 4; i++) begin
        k[i] = key[16*i +: 16];  // k0 is the lowest word
    end
    for (int i = 4; i < 32; i++) begin
        tmp  = rotr16(k[i-1], 3) ^ k[i-3];
        tmp  = tmp ^ rotr16(tmp, 1);
        k[i] = ~k[i-4] ^ tmp ^ {15'd0, model_z0[61 - (i - 4)]} ^ 16'd3;
    end
    return k[idx];
endfunction

function automatic logic [31:0] encrypt_block(input logic [63:0] key, input logic [31:0] pt);
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] t;
    x = pt[31:16];
    y = pt[15:0];
    for (int r = 0; r < 32; r++) begin
        t = x;
        x = y ^ round_fn(x) ^ expand_round_key(key, r);
        y = t;
    end
    return {x, y};
endfunction

function automatic logic [31:0] decrypt_block(input logic [63:0] key, input logic [31:0] ct);
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] t;
    x = ct[31:16];
    y = ct[15:0];
    for (int r = 31; r >= 0; r--) begin
        t = y;
        y = x ^ round_fn(y) ^ expand_round_key(key, r);
        x = t;
    end
    return {x, y};
endfunction

// Taps 32, 22, 2, 1; new bit enters at the bottom
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`default_nettype wire

`endif

//--- tb/simon_crypto_tb.sv
`timescale 1ns/1ps
`include "simon_tb_model.svh"
`default_nettype none

module simon_crypto_tb
    import simon_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 4;
    localparam int ack_limit    = 4;   // Edges per bus phase
    localparam int xfer_cycles  = 10;
    localparam int done_polls   = 24;
    localparam int poll_cycles  = done_polls * xfer_cycles;
    localparam int num_random   = 10;
    localparam int test_cycles  = 12 * xfer_cycles
                                + (9 * xfer_cycles + poll_cycles)
                                + (4 * xfer_cycles + poll_cycles)
                                + num_random * (7 * xfer_cycles + 2 * poll_cycles)
                                + (16 * xfer_cycles + 4 * poll_cycles)
                                + (7 * xfer_cycles + poll_cycles);
    localparam int watchdog_ns  = (reset_cycles + 8 + test_cycles) * clk_period;

    logic        clk;
    logic        reset;
    logic        req;
    bus_req_t    bus_in;
    logic        ack;
    bus_rsp_t    bus_out;
    logic [31:0] lfsr_state;

    simon_crypto_top simon_crypto_top_inst (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .bus_in  (bus_in),
        .ack     (ack),
        .bus_out (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ************************************************************
    // Reporting and bus helpers
    // ************************************************************
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch at %0t: %s got %08h expected %08h",
                               $time, name, got, exp));
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (ack !== level && cycles < ack_limit);
        assert (ack === level) else begin
            fail_run($sformatf("ack did not %s within %0d cycles",
                               level ? "rise" : "fall", ack_limit));
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_in.write <= 1'b1;
        bus_in.addr  <= addr;
        bus_in.wdata <= data;
        req          <= 1'b1;
        wait_ack(1'b1);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        bus_in.write <= 1'b0;
        bus_in.addr  <= addr;
        bus_in.wdata <= '0;
        req          <= 1'b1;
        wait_ack(1'b1);
        data = bus_out.rdata;  // Valid while ack is high
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        bus_read(addr, data);
        check_value(name, data, exp);
    endtask

    task automatic poll_until(input logic [7:0] addr, input logic [31:0] mask,
                              input logic [31:0] value, input string what);
        logic [31:0] data;
        int          polls;
        polls = 0;
        do begin
            bus_read(addr, data);
            polls++;
        end while ((data & mask) !== value && polls < done_polls);
        assert ((data & mask) === value) else begin
            fail_run($sformatf("%s not seen within %0d polls", what, done_polls));
        end
    endtask

    task automatic wait_done(input logic [7:0] addr, input string what);
        poll_until(addr, 32'h1, 32'h1, what);
    endtask

    task automatic load_key(input logic [63:0] key);
        bus_write(addr_key_lo, key[31:0]);
        bus_write(addr_key_hi, key[63:32]);  // Starts expansion
    endtask

    task automatic random_value(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************
    task automatic reset_values_read_zero();
        for (int a = 0; a < 12; a++) begin
            check_read(8'(a), 32'h0, $sformatf("rdata at addr %0d", a));
        end
    endtask

    task automatic published_vector_encrypts();
        check_value("encrypt_block", encrypt_block(64'h1918111009080100, 32'h65656877),
                    32'hc69be9bb);
        load_key(64'h1918111009080100);
        bus_write(addr_plaintext, 32'h65656877);
        check_read(addr_key_lo, 32'h09080100, "key low word");
        check_read(addr_key_hi, 32'h19181110, "key high word");
        check_read(addr_plaintext, 32'h65656877, "plaintext");
        bus_write(addr_enc_start, 32'h1);
        wait_done(addr_enc_done, "encrypt done");
        check_read(addr_enc_done, 32'h0, "enc done after read");
        check_read(addr_enc_result, 32'hc69be9bb, "enc result");
    endtask

    task automatic published_vector_decrypts();
        bus_write(addr_ciphertext, 32'hc69be9bb);
        check_read(addr_ciphertext, 32'hc69be9bb, "ciphertext");
        bus_write(addr_dec_start, 32'h1);
        wait_done(addr_dec_done, "decrypt done");
        check_read(addr_dec_result, 32'h65656877, "dec result");
    endtask

    task automatic random_blocks_round_trip();
        logic [63:0] key;
        logic [63:0] blk;
        logic [31:0] ct;
        for (int i = 0; i < num_random; i++) begin
            random_value(64, key);
            random_value(32, blk);
            ct = encrypt_block(key, blk[31:0]);
            load_key(key);
            bus_write(addr_plaintext, blk[31:0]);
            bus_write(addr_enc_start, 32'h1);
            wait_done(addr_enc_done, "encrypt done");
            check_read(addr_enc_result, ct, "enc result");
            bus_write(addr_ciphertext, ct);  // Feed the result back
            bus_write(addr_dec_start, 32'h1);
            wait_done(addr_dec_done, "decrypt done");
            check_read(addr_dec_result, blk[31:0], "dec result");
        end
    endtask

    task automatic back_to_back_operations();
        logic [63:0] key;
        logic [63:0] pt;
        logic [63:0] ct;
        random_value(64, key);
        random_value(32, pt);
        random_value(32, ct);
        load_key(key);
        bus_write(addr_plaintext, pt[31:0]);
        bus_write(addr_ciphertext, ct[31:0]);
        bus_write(addr_enc_start, 32'h1);
        bus_write(addr_dec_start, 32'h1);
        wait_done(addr_enc_done, "encrypt done");
        wait_done(addr_dec_done, "decrypt done");
        check_read(addr_enc_result, encrypt_block(key, pt[31:0]), "enc result");
        check_read(addr_dec_result, decrypt_block(key, ct[31:0]), "dec result");

        // Leave both flags pending, then clear only the encrypt side
        bus_write(addr_enc_start, 32'h1);
        bus_write(addr_dec_start, 32'h1);
        poll_until(addr_status, 32'h7, 32'h0, "idle status");
        random_value(32, pt);
        bus_write(addr_plaintext, pt[31:0]);
        check_read(addr_enc_done, 32'h0, "enc done after plaintext write");
        check_read(addr_dec_done, 32'h1, "dec done still pending");
    endtask

    task automatic start_waits_for_new_key();
        logic [63:0] key;
        logic [63:0] pt;
        logic [31:0] status;
        random_value(64, key);
        random_value(32, pt);
        bus_write(addr_plaintext, pt[31:0]);
        load_key(key);
        bus_write(addr_enc_start, 32'h1);
        bus_read(addr_status, status);
        check_value("status key and enc busy", status & 32'h3, 32'h3);
        wait_done(addr_enc_done, "encrypt done");
        check_read(addr_enc_result, encrypt_block(key, pt[31:0]), "enc result");
    endtask

    // ************************************************************
    // Main sequence and watchdog
    // ************************************************************
    initial begin
        reset      = 1'b0;
        req        = 1'b0;
        bus_in     = '0;
        lfsr_state = 32'hda5;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b1;

        reset_values_read_zero();
        published_vector_encrypts();
        published_vector_decrypts();
        random_blocks_round_trip();
        back_to_back_operations();
        start_waits_for_new_key();

        $display("All checks passed");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        fail_run($sformatf("watchdog expired after %0d ns", watchdog_ns));
    end

endmodule

`default_nettype wire

//--- simon_crypto_top.f
+incdir+tb
rtl/simon_pkg.sv
rtl/simon_key_schedule.sv
rtl/simon_round_core.sv
rtl/simon_reg_block.sv
rtl/simon_crypto_top.sv
tb/simon_crypto_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := simon_crypto_tb
FILELIST  := simon_crypto_top.f
PASS_MSG  := All checks passed

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
